/* mips_ex_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// MIPS32 opcode and funct codes, ALU and memory-size encodings,
// and the instruction word with its R-type and I-type views
////////////////////////////////////////////////////////////////////////////
package mips_ex_pkg;

  // Primary opcodes
  localparam logic [5:0] opc_special = 6'b000000;
  localparam logic [5:0] opc_addiu   = 6'b001001;
  localparam logic [5:0] opc_lui     = 6'b001111;
  localparam logic [5:0] opc_lb      = 6'b100000;
  localparam logic [5:0] opc_lh      = 6'b100001;
  localparam logic [5:0] opc_lw      = 6'b100011;
  localparam logic [5:0] opc_lbu     = 6'b100100;
  localparam logic [5:0] opc_lhu     = 6'b100101;
  localparam logic [5:0] opc_sb      = 6'b101000;
  localparam logic [5:0] opc_sh      = 6'b101001;
  localparam logic [5:0] opc_sw      = 6'b101011;

  // SPECIAL funct codes
  localparam logic [5:0] fn_movz = 6'b001010;
  localparam logic [5:0] fn_movn = 6'b001011;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_xor  = 6'b100110;
  localparam logic [5:0] fn_slt  = 6'b101010;
  localparam logic [5:0] fn_teq  = 6'b110100;
  localparam logic [5:0] fn_tne  = 6'b110110;

  // alu_mov copies operand A, used by MOVZ/MOVN
  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui, alu_mov
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_word, mem_half, mem_byte
  } mem_size_e;

  typedef union packed {
    struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
  } instr_word_u;

endpackage

/* ex_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction decoder producing the execute-stage controls
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_decoder
  import mips_ex_pkg::*;
(
  input  instr_word_u instr,
  output alu_op_e     alu_op,
  output logic        use_imm,
  output logic        imm_signed,
  output logic        gpr_we,
  output logic        rd_is_rt,
  output logic        mem_to_gpr_select,
  output logic        mem_write,
  output logic        sign_ext,
  output logic        movz,
  output logic        movn,
  output logic        trap,
  output logic        trap_on_equal,
  output logic        mem_exception_source,
  output mem_size_e   mem_size,
  output logic [4:0]  gpr_wa
);

  always_comb begin
    // Unknown encodings fall through as a bubble
    alu_op               = alu_add;
    use_imm              = 1'b0;
    imm_signed           = 1'b0;
    gpr_we               = 1'b0;
    rd_is_rt             = 1'b0;
    mem_to_gpr_select    = 1'b0;
    mem_write            = 1'b0;
    sign_ext             = 1'b0;
    movz                 = 1'b0;
    movn                 = 1'b0;
    trap                 = 1'b0;
    trap_on_equal        = 1'b0;
    mem_exception_source = 1'b0;
    mem_size             = mem_word;

    if (instr.r.op == opc_special) begin
      gpr_we = 1'b1;
      case (instr.r.funct)
        fn_addu: alu_op = alu_add;
        fn_subu: alu_op = alu_sub;
        fn_and:  alu_op = alu_and;
        fn_or:   alu_op = alu_or;
        fn_xor:  alu_op = alu_xor;
        fn_slt:  alu_op = alu_slt;
        fn_movz: begin
          alu_op = alu_mov;
          movz   = 1'b1;
        end
        fn_movn: begin
          alu_op = alu_mov;
          movn   = 1'b1;
        end
        fn_teq, fn_tne: begin
          gpr_we        = 1'b0;
          trap          = 1'b1;
          trap_on_equal = (instr.r.funct == fn_teq);
        end
        default: gpr_we = 1'b0;
      endcase
    end else begin
      // I-type: ADDIU and all memory ops take a sign-extended offset
      use_imm    = 1'b1;
      imm_signed = 1'b1;
      rd_is_rt   = 1'b1;
      case (instr.i.op)
        opc_addiu: gpr_we = 1'b1;
        opc_lui: begin
          gpr_we     = 1'b1;
          imm_signed = 1'b0;
          alu_op     = alu_lui;
        end
        opc_lw, opc_lh, opc_lhu, opc_lb, opc_lbu: begin
          gpr_we               = 1'b1;
          mem_to_gpr_select    = 1'b1;
          mem_exception_source = 1'b1;
          sign_ext             = (instr.i.op == opc_lh) || (instr.i.op == opc_lb);
          if (instr.i.op == opc_lh || instr.i.op == opc_lhu)
            mem_size = mem_half;
          else if (instr.i.op == opc_lb || instr.i.op == opc_lbu)
            mem_size = mem_byte;
        end
        opc_sw, opc_sh, opc_sb: begin
          mem_write            = 1'b1;
          mem_exception_source = 1'b1;
          if (instr.i.op == opc_sh)
            mem_size = mem_half;
          else if (instr.i.op == opc_sb)
            mem_size = mem_byte;
        end
        default: begin
          use_imm    = 1'b0;
          imm_signed = 1'b0;
          rd_is_rt   = 1'b0;
        end
      endcase
    end
  end

  assign gpr_wa = rd_is_rt ? instr.i.rt : instr.r.rd;

endmodule

/* ex_alu.sv */
////////////////////////////////////////////////////////////////////////////
// Execute-stage ALU with store data, B-zero flag and trap condition
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_alu
  import mips_ex_pkg::*;
(
  input  logic [31:0] rs_data,
  input  logic [31:0] rt_data,
  input  logic [31:0] imm_word,
  input  alu_op_e     alu_op,
  input  logic        use_imm,
  input  logic        trap_on_equal,
  output logic [31:0] alu_result,
  output logic [31:0] store_data,
  output logic        b_is_zero,
  output logic        trap_condition
);

  logic [31:0] b_operand;

  // Immediate forms, including load/store effective address
  assign b_operand = use_imm ? imm_word : rt_data;

  always_comb begin
    case (alu_op)
      alu_add: alu_result = rs_data + b_operand;
      alu_sub: alu_result = rs_data - b_operand;
      alu_and: alu_result = rs_data & b_operand;
      alu_or:  alu_result = rs_data | b_operand;
      alu_xor: alu_result = rs_data ^ b_operand;
      alu_slt: alu_result = {31'b0, $signed(rs_data) < $signed(b_operand)};
      alu_lui: alu_result = {b_operand[15:0], 16'h0000};
      alu_mov: alu_result = rs_data;
      default: alu_result = 32'h0;
    endcase
  end

  assign store_data = rt_data;
  assign b_is_zero  = (rt_data == 32'h0);

  // TEQ traps on equal, TNE on not equal
  assign trap_condition = trap_on_equal ? (rs_data == rt_data) : (rs_data != rt_data);

endmodule

/* antares_exmem_register.sv */
////////////////////////////////////////////////////////////////////////////
// EX/MEM pipeline register with stall hold, bubble insertion
// and the MOVZ/MOVN write-enable fold
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module antares_exmem_register (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] ex_alu_result,
  input  logic [31:0] ex_mem_store_data,
  input  logic [4:0]  ex_gpr_wa,
  input  logic        ex_gpr_we,
  input  logic        ex_mem_to_gpr_select,
  input  logic        ex_mem_write,
  input  logic        ex_mem_byte,
  input  logic        ex_mem_halfword,
  input  logic        ex_mem_data_sign_ext,
  input  logic [31:0] ex_exception_pc,
  input  logic        ex_movz,
  input  logic        ex_movn,
  input  logic        ex_b_is_zero,
  input  logic        ex_trap,
  input  logic        ex_trap_condition,
  input  logic        ex_mem_exception_source,
  input  logic        ex_stall,
  input  logic        ex_flush,
  input  logic        mem_stall,
  output logic [31:0] mem_alu_result,
  output logic [31:0] mem_mem_store_data,
  output logic [4:0]  mem_gpr_wa,
  output logic        mem_gpr_we,
  output logic        mem_mem_to_gpr_select,
  output logic        mem_mem_write,
  output logic        mem_mem_byte,
  output logic        mem_mem_halfword,
  output logic        mem_mem_data_sign_ext,
  output logic [31:0] mem_exception_pc,
  output logic        mem_trap,
  output logic        mem_trap_condition,
  output logic        mem_mem_exception_source
);

  logic bubble;
  logic gpr_we_next;

  assign bubble = ex_stall || ex_flush;

  // Conditional moves decide the write from rt alone
  assign gpr_we_next = ex_movn ? !ex_b_is_zero :
                       ex_movz ?  ex_b_is_zero : ex_gpr_we;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_alu_result           <= 32'h0;
      mem_mem_store_data       <= 32'h0;
      mem_gpr_wa               <= 5'h0;
      mem_gpr_we               <= 1'b0;
      mem_mem_to_gpr_select    <= 1'b0;
      mem_mem_write            <= 1'b0;
      mem_mem_byte             <= 1'b0;
      mem_mem_halfword         <= 1'b0;
      mem_mem_data_sign_ext    <= 1'b0;
      mem_exception_pc         <= 32'h0;
      mem_trap                 <= 1'b0;
      mem_trap_condition       <= 1'b0;
      mem_mem_exception_source <= 1'b0;
    end else if (!mem_stall) begin
      mem_alu_result           <= ex_alu_result;
      mem_mem_store_data       <= ex_mem_store_data;
      mem_gpr_wa               <= ex_gpr_wa;
      mem_mem_byte             <= ex_mem_byte;
      mem_mem_halfword         <= ex_mem_halfword;
      mem_mem_data_sign_ext    <= ex_mem_data_sign_ext;
      mem_exception_pc         <= ex_exception_pc;
      mem_trap_condition       <= ex_trap_condition;
      // A stalled or flushed slot enters as a bubble
      mem_gpr_we               <= bubble ? 1'b0 : gpr_we_next;
      mem_mem_to_gpr_select    <= bubble ? 1'b0 : ex_mem_to_gpr_select;
      mem_mem_write            <= bubble ? 1'b0 : ex_mem_write;
      mem_trap                 <= bubble ? 1'b0 : ex_trap;
      mem_mem_exception_source <= bubble ? 1'b0 : ex_mem_exception_source;
    end
  end

  a_reset_clears: assert property (@(posedge clk)
    reset |=> {mem_alu_result, mem_mem_store_data, mem_gpr_wa, mem_gpr_we,
               mem_mem_to_gpr_select, mem_mem_write, mem_mem_byte, mem_mem_halfword,
               mem_mem_data_sign_ext, mem_exception_pc, mem_trap, mem_trap_condition,
               mem_mem_exception_source} == '0);

  a_stall_holds: assert property (@(posedge clk) disable iff (reset)
    mem_stall |=> $stable({mem_alu_result, mem_mem_store_data, mem_gpr_wa, mem_gpr_we,
                           mem_mem_to_gpr_select, mem_mem_write, mem_mem_byte,
                           mem_mem_halfword, mem_mem_data_sign_ext, mem_exception_pc,
                           mem_trap, mem_trap_condition, mem_mem_exception_source}));

  a_bubble_gated: assert property (@(posedge clk) disable iff (reset)
    !mem_stall && bubble |=> {mem_gpr_we, mem_mem_to_gpr_select, mem_mem_write,
                              mem_trap, mem_mem_exception_source} == 5'b0);

endmodule

/* mem_access.sv */
////////////////////////////////////////////////////////////////////////////
// Memory stage with data RAM, big-endian lanes, load extension,
// alignment and trap exceptions and the write-back port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_access #(
  parameter int DMEM_WORDS = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] mem_alu_result,
  input  logic [31:0] mem_mem_store_data,
  input  logic [31:0] mem_exception_pc,
  input  logic [4:0]  mem_gpr_wa,
  input  logic        mem_gpr_we,
  input  logic        mem_mem_to_gpr_select,
  input  logic        mem_mem_write,
  input  logic        mem_mem_byte,
  input  logic        mem_mem_halfword,
  input  logic        mem_mem_data_sign_ext,
  input  logic        mem_trap,
  input  logic        mem_trap_condition,
  input  logic        mem_mem_exception_source,
  output logic        wb_gpr_we,
  output logic [4:0]  wb_gpr_wa,
  output logic [31:0] wb_gpr_wd,
  output logic        exc_addr_error,
  output logic        exc_trap,
  output logic [31:0] exc_pc
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [31:0]   dmem [DMEM_WORDS];
  logic [AW-1:0] word_idx;
  logic [1:0]    offset;
  logic [4:0]    lane_shift;
  logic [31:0]   rd_word;
  logic [31:0]   lane_data;
  logic [31:0]   lane_mask;
  logic [31:0]   merged;
  logic [31:0]   load_data;
  logic          exc_any;
  logic          store_en;

  // Word index wraps modulo the RAM size
  assign word_idx   = mem_alu_result[AW+1:2];
  assign offset     = mem_alu_result[1:0];
  assign lane_shift = 5'((3 - offset) * 8);
  assign rd_word    = dmem[word_idx];

  always_comb begin
    if (mem_mem_byte) begin
      lane_mask = 32'h0000_00ff << lane_shift;
      lane_data = {4{mem_mem_store_data[7:0]}};
    end else if (mem_mem_halfword) begin
      lane_mask = offset[1] ? 32'h0000_ffff : 32'hffff_0000;
      lane_data = {2{mem_mem_store_data[15:0]}};
    end else begin
      lane_mask = 32'hffff_ffff;
      lane_data = mem_mem_store_data;
    end
  end

  assign merged = (rd_word & ~lane_mask) | (lane_data & lane_mask);

  // Extract the addressed lane, then extend it
  always_comb begin
    logic [31:0] shifted;
    shifted = rd_word >> lane_shift;
    if (mem_mem_byte)
      load_data = {{24{mem_mem_data_sign_ext & shifted[7]}}, shifted[7:0]};
    else if (mem_mem_halfword)
      load_data = offset[1] ? {{16{mem_mem_data_sign_ext & rd_word[15]}}, rd_word[15:0]}
                            : {{16{mem_mem_data_sign_ext & rd_word[31]}}, rd_word[31:16]};
    else
      load_data = rd_word;
  end

  assign exc_addr_error = mem_mem_exception_source &&
                          ((mem_mem_halfword && offset[0]) ||
                           (!mem_mem_byte && !mem_mem_halfword && offset != 2'b00));
  assign exc_trap = mem_trap && mem_trap_condition;
  assign exc_pc   = mem_exception_pc;
  assign exc_any  = exc_addr_error || exc_trap;
  assign store_en = mem_mem_write && !exc_any;

  always_ff @(posedge clk) begin
    if (!reset && store_en)
      dmem[word_idx] <= merged;
  end

  assign wb_gpr_we = mem_gpr_we && !exc_any;
  assign wb_gpr_wa = mem_gpr_wa;
  assign wb_gpr_wd = mem_mem_to_gpr_select ? load_data : mem_alu_result;

  // A faulting slot leaves the addressed word untouched
  a_no_write_on_exc: assert property (@(posedge clk) disable iff (reset)
    exc_any |=> dmem[$past(word_idx)] == $past(rd_word));

endmodule

/* ex_mem_top.sv */
////////////////////////////////////////////////////////////////////////////
// Execute-to-memory slice: decoder, ALU, EX/MEM register, memory stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_mem_top
  import mips_ex_pkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instr,
  input  logic [31:0] rs_data,
  input  logic [31:0] rt_data,
  input  logic [31:0] pc,
  input  logic        ex_stall,
  input  logic        ex_flush,
  input  logic        mem_stall,
  output logic        wb_gpr_we,
  output logic [4:0]  wb_gpr_wa,
  output logic [31:0] wb_gpr_wd,
  output logic        exc_addr_error,
  output logic        exc_trap,
  output logic [31:0] exc_pc
);

  instr_word_u instr_w;
  alu_op_e     alu_op;
  mem_size_e   mem_size;
  logic [31:0] imm_word;
  logic [31:0] alu_result;
  logic [31:0] store_data;
  logic [4:0]  gpr_wa;
  logic        use_imm;
  logic        imm_signed;
  logic        gpr_we;
  logic        mem_to_gpr_select;
  logic        mem_write;
  logic        sign_ext;
  logic        movz;
  logic        movn;
  logic        trap;
  logic        trap_on_equal;
  logic        mem_exception_source;
  logic        b_is_zero;
  logic        trap_condition;
  logic [31:0] m_alu_result;
  logic [31:0] m_store_data;
  logic [31:0] m_exception_pc;
  logic [4:0]  m_gpr_wa;
  logic        m_gpr_we;
  logic        m_to_gpr_select;
  logic        m_write;
  logic        m_byte;
  logic        m_halfword;
  logic        m_sign_ext;
  logic        m_trap;
  logic        m_trap_condition;
  logic        m_exception_source;

  assign instr_w = instr;

  ex_decoder u_decoder (
    .instr(instr_w), .alu_op(alu_op), .use_imm(use_imm), .imm_signed(imm_signed),
    .gpr_we(gpr_we), .rd_is_rt(), .mem_to_gpr_select(mem_to_gpr_select),
    .mem_write(mem_write), .sign_ext(sign_ext), .movz(movz), .movn(movn),
    .trap(trap), .trap_on_equal(trap_on_equal),
    .mem_exception_source(mem_exception_source), .mem_size(mem_size), .gpr_wa(gpr_wa)
  );

  // Sign-extended offset, or raw upper-half value for LUI
  assign imm_word = imm_signed ? {{16{instr_w.i.imm[15]}}, instr_w.i.imm}
                               : {16'h0000, instr_w.i.imm};

  ex_alu u_alu (
    .rs_data(rs_data), .rt_data(rt_data), .imm_word(imm_word), .alu_op(alu_op),
    .use_imm(use_imm), .trap_on_equal(trap_on_equal), .alu_result(alu_result),
    .store_data(store_data), .b_is_zero(b_is_zero), .trap_condition(trap_condition)
  );

  antares_exmem_register u_exmem (
    .clk(clk), .reset(reset),
    .ex_alu_result(alu_result), .ex_mem_store_data(store_data), .ex_gpr_wa(gpr_wa),
    .ex_gpr_we(gpr_we), .ex_mem_to_gpr_select(mem_to_gpr_select),
    .ex_mem_write(mem_write), .ex_mem_byte(mem_size == mem_byte),
    .ex_mem_halfword(mem_size == mem_half), .ex_mem_data_sign_ext(sign_ext),
    .ex_exception_pc(pc), .ex_movz(movz), .ex_movn(movn), .ex_b_is_zero(b_is_zero),
    .ex_trap(trap), .ex_trap_condition(trap_condition),
    .ex_mem_exception_source(mem_exception_source),
    .ex_stall(ex_stall), .ex_flush(ex_flush), .mem_stall(mem_stall),
    .mem_alu_result(m_alu_result), .mem_mem_store_data(m_store_data),
    .mem_gpr_wa(m_gpr_wa), .mem_gpr_we(m_gpr_we),
    .mem_mem_to_gpr_select(m_to_gpr_select), .mem_mem_write(m_write),
    .mem_mem_byte(m_byte), .mem_mem_halfword(m_halfword),
    .mem_mem_data_sign_ext(m_sign_ext), .mem_exception_pc(m_exception_pc),
    .mem_trap(m_trap), .mem_trap_condition(m_trap_condition),
    .mem_mem_exception_source(m_exception_source)
  );

  mem_access #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
    .clk(clk), .reset(reset),
    .mem_alu_result(m_alu_result), .mem_mem_store_data(m_store_data),
    .mem_exception_pc(m_exception_pc), .mem_gpr_wa(m_gpr_wa), .mem_gpr_we(m_gpr_we),
    .mem_mem_to_gpr_select(m_to_gpr_select), .mem_mem_write(m_write),
    .mem_mem_byte(m_byte), .mem_mem_halfword(m_halfword),
    .mem_mem_data_sign_ext(m_sign_ext), .mem_trap(m_trap),
    .mem_trap_condition(m_trap_condition),
    .mem_mem_exception_source(m_exception_source),
    .wb_gpr_we(wb_gpr_we), .wb_gpr_wa(wb_gpr_wa), .wb_gpr_wd(wb_gpr_wd),
    .exc_addr_error(exc_addr_error), .exc_trap(exc_trap), .exc_pc(exc_pc)
  );

endmodule

/* tb_ex_mem_top.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the execute-to-memory slice with a cycle-level model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ex_mem_top
  import mips_ex_pkg::*;
;

  localparam int n_alu_ops   = 200;
  localparam int n_fill      = 16;
  localparam int n_mem       = 200;
  localparam int n_exc       = 120;
  localparam int n_mix       = 300;
  localparam int cycle_limit = 4 + n_alu_ops + 2 * n_fill + n_mem + n_exc + n_mix + 20;

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] pc;
  logic        ex_stall;
  logic        ex_flush;
  logic        mem_stall;
  logic        wb_gpr_we;
  logic [4:0]  wb_gpr_wa;
  logic [31:0] wb_gpr_wd;
  logic        exc_addr_error;
  logic        exc_trap;
  logic [31:0] exc_pc;

  // Model: shadow RAM, registered slot (p_) and the slot being issued (n_)
  logic [31:0] shadow [64];
  logic [31:0] p_alu, p_store, p_pc, n_alu, n_store, n_pc;
  logic [4:0]  p_wa, n_wa;
  logic        p_we, p_to_gpr, p_write, p_trap, p_tcond, p_memsrc, p_sext;
  logic        n_we, n_to_gpr, n_write, n_trap, n_tcond, n_memsrc, n_sext;
  mem_size_e   p_size, n_size;

  logic [31:0] lfsr = 32'h6fa8;
  int          errors = 0;
  int          checks = 0;
  int          test_num = 0;
  int          test_start_errors = 0;
  int          cycle_count;
  int          exc_kinds [7] = '{12, 13, 14, 17, 18, 8, 9};

  ex_mem_top #(.DMEM_WORDS(64)) u_ex_mem_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Kinds 0-9: addu subu and or xor slt movz movn teq tne
  // Kinds 10-19: addiu lui lw lh lhu lb lbu sw sh sb
  function automatic logic [31:0] build_instr(input int kind, input logic [4:0] rs_idx,
                                              input logic [4:0] rt_idx, input logic [4:0] rd,
                                              input logic [15:0] imm);
    logic [5:0]  fn_tab [10];
    logic [5:0]  op_tab [10];
    instr_word_u w;
    fn_tab = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_movz, fn_movn,
               fn_teq, fn_tne};
    op_tab = '{opc_addiu, opc_lui, opc_lw, opc_lh, opc_lhu, opc_lb, opc_lbu, opc_sw,
               opc_sh, opc_sb};
    if (kind < 10) begin
      w.r.op    = opc_special;
      w.r.rs    = rs_idx;
      w.r.rt    = rt_idx;
      w.r.rd    = rd;
      w.r.shamt = 5'h0;
      w.r.funct = fn_tab[kind];
    end else begin
      w.i.op  = op_tab[kind - 10];
      w.i.rs  = rs_idx;
      w.i.rt  = rt_idx;
      w.i.imm = imm;
    end
    return w;
  endfunction

  function automatic mem_size_e kind_size(input int kind);
    case (kind)
      13, 14, 18: return mem_half;
      15, 16, 19: return mem_byte;
      default:    return mem_word;
    endcase
  endfunction

  function automatic logic model_addr_error();
    return p_memsrc && ((p_size == mem_half && p_alu[0]) ||
                        (p_size == mem_word && p_alu[1:0] != 2'b00));
  endfunction

  function automatic logic model_trap();
    return p_trap && p_tcond;
  endfunction

  // Big-endian lane pick, byte 0 in bits 31..24
  function automatic logic [31:0] load_value(input logic [31:0] w, input logic [1:0] off,
                                             input mem_size_e size, input logic sext);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8 * (3 - off) +: 8];
    h = w[16 * (1 - off[1]) +: 16];
    case (size)
      mem_byte: return {{24{sext & b[7]}}, b};
      mem_half: return {{16{sext & h[15]}}, h};
      default:  return w;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("ERROR time %0t: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic predict(input int kind, input logic [31:0] rs_v, input logic [31:0] rt_v,
                         input logic [31:0] pc_v, input logic [15:0] imm,
                         input logic [4:0] rt_idx, input logic [4:0] rd, input logic bubble);
    n_alu    = rs_v + {{16{imm[15]}}, imm};
    n_store  = rt_v;
    n_pc     = pc_v;
    n_wa     = (kind < 10) ? rd : rt_idx;
    n_we     = 1'b1;
    n_to_gpr = 1'b0;
    n_write  = 1'b0;
    n_trap   = 1'b0;
    n_tcond  = 1'b0;
    n_memsrc = 1'b0;
    n_sext   = (kind == 13) || (kind == 15);
    n_size   = kind_size(kind);
    case (kind)
      0: n_alu = rs_v + rt_v;
      1: n_alu = rs_v - rt_v;
      2: n_alu = rs_v & rt_v;
      3: n_alu = rs_v | rt_v;
      4: n_alu = rs_v ^ rt_v;
      5: n_alu = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
      6, 7: begin
        n_alu = rs_v;
        n_we  = (kind == 6) ? (rt_v == 32'h0) : (rt_v != 32'h0);
      end
      8, 9: begin
        n_we    = 1'b0;
        n_trap  = 1'b1;
        n_tcond = (kind == 8) ? (rs_v == rt_v) : (rs_v != rt_v);
      end
      11: n_alu = {imm, 16'h0000};
      12, 13, 14, 15, 16: begin
        n_to_gpr = 1'b1;
        n_memsrc = 1'b1;
      end
      17, 18, 19: begin
        n_we     = 1'b0;
        n_write  = 1'b1;
        n_memsrc = 1'b1;
      end
      default: ;
    endcase
    if (bubble) begin
      n_we     = 1'b0;
      n_to_gpr = 1'b0;
      n_write  = 1'b0;
      n_trap   = 1'b0;
      n_memsrc = 1'b0;
    end
  endtask

  // Store from the registered slot, then load the new slot unless held
  task automatic commit(input logic mem_st);
    logic [31:0] w;
    if (p_write && !model_addr_error() && !model_trap()) begin
      w = shadow[p_alu[7:2]];
      case (p_size)
        mem_byte: w[8 * (3 - p_alu[1:0]) +: 8] = p_store[7:0];
        mem_half: w[16 * (1 - p_alu[1]) +: 16] = p_store[15:0];
        default:  w = p_store;
      endcase
      shadow[p_alu[7:2]] = w;
    end
    if (!mem_st) begin
      p_alu    = n_alu;
      p_store  = n_store;
      p_pc     = n_pc;
      p_wa     = n_wa;
      p_we     = n_we;
      p_to_gpr = n_to_gpr;
      p_write  = n_write;
      p_trap   = n_trap;
      p_tcond  = n_tcond;
      p_memsrc = n_memsrc;
      p_sext   = n_sext;
      p_size   = n_size;
    end
  endtask

  // A held slot keeps its model values, so a stall is checked the same way
  task automatic compare_outputs();
    logic ae;
    logic te;
    logic we;
    ae = model_addr_error();
    te = model_trap();
    we = p_we && !ae && !te;
    check_value("wb_gpr_we", we, wb_gpr_we);
    check_value("exc_addr_error", ae, exc_addr_error);
    check_value("exc_trap", te, exc_trap);
    check_value("exc_pc", p_pc, exc_pc);
    if (we) begin
      check_value("wb_gpr_wa", p_wa, wb_gpr_wa);
      check_value("wb_gpr_wd", p_to_gpr ? load_value(shadow[p_alu[7:2]], p_alu[1:0],
                  p_size, p_sext) : p_alu, wb_gpr_wd);
    end
  endtask

  // One instruction slot, driven at the falling edge
  task automatic issue(input int kind, input logic [31:0] rs_v, input logic [31:0] rt_v,
                       input logic [15:0] imm, input logic ex_st, input logic ex_fl,
                       input logic mem_st);
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [4:0]  rd;
    logic [31:0] pc_v;
    rs_idx    = 5'(take_bits(5));
    rt_idx    = 5'(take_bits(5));
    rd        = 5'(take_bits(5));
    pc_v      = take_bits(30) << 2;
    instr     = build_instr(kind, rs_idx, rt_idx, rd, imm);
    rs_data   = rs_v;
    rt_data   = rt_v;
    pc        = pc_v;
    ex_stall  = ex_st;
    ex_flush  = ex_fl;
    mem_stall = mem_st;
    predict(kind, rs_v, rt_v, pc_v, imm, rt_idx, rd, ex_st || ex_fl);
    @(posedge clk);
    commit(mem_st);
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic random_issue(input int kind, input logic misalign, input logic ex_st,
                              input logic ex_fl, input logic mem_st);
    logic [31:0] rs_v;
    logic [31:0] rt_v;
    logic [31:0] target;
    logic [15:0] imm;
    logic [3:0]  ofs_bits;
    logic [1:0]  off;
    rs_v = take_bits(32);
    rt_v = take_bits(32);
    imm  = 16'(take_bits(16));
    if (kind >= 12) begin
      // Word addresses 0..15 so loads hit earlier stores
      target   = take_bits(4) << 2;
      off      = 2'(take_bits(2));
      ofs_bits = 4'(take_bits(4));
      if (kind_size(kind) == mem_half)
        off[0] = misalign;
      else if (kind_size(kind) == mem_word && !misalign)
        off = 2'b00;
      else if (kind_size(kind) == mem_word && off == 2'b00)
        off = 2'b11;
      imm  = {{12{ofs_bits[3]}}, ofs_bits};
      rs_v = target + {30'b0, off} - {{16{imm[15]}}, imm};
    end
    if ((kind == 6 || kind == 7) && take_bits(1))
      rt_v = 32'h0;
    if ((kind == 8 || kind == 9) && take_bits(1))
      rt_v = rs_v;
    issue(kind, rs_v, rt_v, imm, ex_st, ex_fl, mem_st);
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("Test %0d %s: %0d errors", test_num, name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not end within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int          kind;
    logic [31:0] data;
    logic        st;
    logic        fl;
    logic        ms;
    reset     = 1'b1;
    instr     = 32'h0;
    rs_data   = 32'h0;
    rt_data   = 32'h0;
    pc        = 32'h0;
    ex_stall  = 1'b0;
    ex_flush  = 1'b0;
    mem_stall = 1'b0;
    {p_alu, p_store, p_pc, p_wa} = '0;
    {p_we, p_to_gpr, p_write, p_trap, p_tcond, p_memsrc, p_sext} = '0;
    p_size = mem_word;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    compare_outputs();
    report_test("reset");

    for (int i = 0; i < n_alu_ops; i++) begin
      kind = int'(take_bits(5) % 12);
      random_issue(kind, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    report_test("alu and immediate");

    // Fill the addressed words before any load
    for (int i = 0; i < n_fill; i++) begin
      data = take_bits(32);
      issue(17, 32'(i * 4), data, 16'h0, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < n_mem; i++) begin
      kind = 12 + int'(take_bits(3));
      random_issue(kind, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    report_test("loads and stores");

    for (int i = 0; i < n_exc; i++) begin
      kind = exc_kinds[take_bits(3) % 7];
      random_issue(kind, 1'b1, 1'b0, 1'b0, 1'b0);
    end
    // Read back every word, faulting stores must not have landed
    for (int i = 0; i < n_fill; i++)
      issue(12, 32'(i * 4), 32'h0, 16'h0, 1'b0, 1'b0, 1'b0);
    report_test("misalignment and traps");

    for (int i = 0; i < n_mix; i++) begin
      kind = int'(take_bits(5) % 20);
      st   = (take_bits(3) == 0);
      fl   = (take_bits(3) == 0);
      ms   = (take_bits(3) == 0);
      random_issue(kind, 1'b0, st, fl, ms);
    end
    report_test("flush and stall");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* all.f */
mips_ex_pkg.sv
ex_decoder.sv
ex_alu.sv
antares_exmem_register.sv
mem_access.sv
ex_mem_top.sv
tb_ex_mem_top.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_ex_mem_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
